// ==== hdl/regblk_pkg.sv ====
// Shared widths, register map, reset values and enums for the APB register block and its testbench.
`default_nettype none

package regblk_pkg;

  // bus and register widths.
  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 8;

  // the block holds seven registers at consecutive word addresses.
  localparam int NUM_REGS = 7;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // one bit per register, used for strobes and hardware write enables.
  typedef logic [NUM_REGS-1:0] reg_sel_t;

  // software access types a register field can take.
  // rc is a read-to-clear register, so its update strobe is the read strobe.
  typedef enum logic [2:0] {
    ACS_RW,
    ACS_RO,
    ACS_WO,
    ACS_W1C,
    ACS_W1S,
    ACS_W0C,
    ACS_RC
  } sw_access_e;

  // states of the APB completer.
  typedef enum logic [1:0] {
    APB_IDLE,
    APB_ACCESS,
    APB_RESP
  } apb_state_e;

  // register addresses, all word aligned.
  localparam addr_t REG_CTRL_ADDR   = 8'h00;
  localparam addr_t REG_ID_ADDR     = 8'h04;
  localparam addr_t REG_KEY_ADDR    = 8'h08;
  localparam addr_t REG_STATUS_ADDR = 8'h0C;
  localparam addr_t REG_EVENT_ADDR  = 8'h10;
  localparam addr_t REG_FLAGS_ADDR  = 8'h14;
  localparam addr_t REG_COUNT_ADDR  = 8'h18;

  // access type of each register, indexed by register number.
  // the order is CTRL, ID, KEY, STATUS, EVENT, FLAGS, COUNT.
  localparam sw_access_e REG_ACCESS [NUM_REGS] = '{
    ACS_RW, ACS_RO, ACS_WO, ACS_W1C, ACS_W1S, ACS_W0C, ACS_RC
  };

  // reset value of each register, in the same order.
  // FLAGS starts all ones because software can only clear it.
  localparam data_t REG_RESET [NUM_REGS] = '{
    32'h0000_0000, 32'h5245_4701, 32'h0000_0000, 32'h0000_0000,
    32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_0000
  };

endpackage

`default_nettype wire

// ==== hdl/apb_access.sv ====
// APB completer front end; turns each setup/access pair into one request pulse with one wait state.
`timescale 1ns/1ps
`default_nettype none

module apb_access (
  input  logic               clk_i,
  input  logic               rst_i,
  // APB requester side.
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  regblk_pkg::addr_t  paddr_i,
  input  regblk_pkg::data_t  pwdata_i,
  // error flag from the address decoder, valid together with req_o.
  input  logic               err_i,
  // request towards the decoder and the register fields.
  output logic               req_o,
  output logic               req_write_o,
  output regblk_pkg::addr_t  req_addr_o,
  output regblk_pkg::data_t  req_wdata_o,
  // APB response.
  output logic               pready_o,
  output logic               pslverr_o
);

  regblk_pkg::apb_state_e state_q;
  regblk_pkg::apb_state_e state_d;

  // error of the transfer in flight, captured in the first access cycle.
  logic err_q;

  // the requester is in the access phase of a transfer.
  logic access_phase;

  assign access_phase = psel_i & penable_i;

  // the request fires in the first access cycle only.
  // once the FSM reaches the response state the same transfer is ignored.
  assign req_o = access_phase & (state_q != regblk_pkg::APB_RESP);

  // APB holds every input stable through the access phase.
  // The request payload is therefore taken straight from the bus.
  assign req_write_o = pwrite_i;
  assign req_addr_o  = paddr_i;
  assign req_wdata_o = pwdata_i;

  // APB_ACCESS marks a selected transfer whose access phase is due next.
  // An access phase seen directly from idle is accepted as well.
  always_comb begin
    state_d = state_q;
    case (state_q)
      regblk_pkg::APB_IDLE: begin
        if (access_phase) begin
          state_d = regblk_pkg::APB_RESP;
        end else if (psel_i) begin
          state_d = regblk_pkg::APB_ACCESS;
        end
      end
      regblk_pkg::APB_ACCESS: begin
        if (access_phase) begin
          state_d = regblk_pkg::APB_RESP;
        end else if (!psel_i) begin
          // the requester dropped the transfer before the access phase.
          state_d = regblk_pkg::APB_IDLE;
        end
      end
      regblk_pkg::APB_RESP: begin
        // the response lasts one cycle, so the transfer ends here.
        state_d = regblk_pkg::APB_IDLE;
      end
      default: begin
        state_d = regblk_pkg::APB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= regblk_pkg::APB_IDLE;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (req_o) begin
        err_q <= err_i;
      end
    end
  end

  // pready is high for exactly the cycle after the first access cycle.
  assign pready_o  = (state_q == regblk_pkg::APB_RESP);
  assign pslverr_o = (state_q == regblk_pkg::APB_RESP) & err_q;

endmodule

`default_nettype wire

// ==== hdl/reg_decode.sv ====
// Address decoder; turns a request into one-hot register strobes and flags bad accesses.
`timescale 1ns/1ps
`default_nettype none

module reg_decode (
  input  logic                 req_i,
  input  logic                 req_write_i,
  input  regblk_pkg::addr_t    req_addr_i,
  // one-hot software strobes, all zero when the access faults.
  output regblk_pkg::reg_sel_t sw_wen_o,
  output regblk_pkg::reg_sel_t sw_ren_o,
  // high with req_i when the access must complete with pslverr.
  output logic                 err_o
);

  // register number of the addressed register.
  logic [$clog2(regblk_pkg::NUM_REGS)-1:0] idx;

  // the address matches a mapped, word-aligned register.
  logic hit;

  // the access type forbids this access.
  logic illegal;

  // one-hot form of idx.
  regblk_pkg::reg_sel_t sel;

  // misaligned addresses match no entry and fall into the default branch.
  always_comb begin
    hit = 1'b1;
    idx = '0;
    case (req_addr_i)
      regblk_pkg::REG_CTRL_ADDR:   idx = 3'd0;
      regblk_pkg::REG_ID_ADDR:     idx = 3'd1;
      regblk_pkg::REG_KEY_ADDR:    idx = 3'd2;
      regblk_pkg::REG_STATUS_ADDR: idx = 3'd3;
      regblk_pkg::REG_EVENT_ADDR:  idx = 3'd4;
      regblk_pkg::REG_FLAGS_ADDR:  idx = 3'd5;
      regblk_pkg::REG_COUNT_ADDR:  idx = 3'd6;
      default:                     hit = 1'b0;
    endcase
  end

  assign sel = regblk_pkg::reg_sel_t'(1) << idx;

  // only a write to a read-only register is illegal.
  // a read of a write-only register succeeds and returns zero.
  assign illegal = req_write_i && (regblk_pkg::REG_ACCESS[idx] == regblk_pkg::ACS_RO);

  assign err_o = req_i & (~hit | illegal);

  // a faulting access leaves every register untouched.
  always_comb begin
    sw_wen_o = '0;
    sw_ren_o = '0;
    if (req_i && hit && !illegal) begin
      if (req_write_i) begin
        sw_wen_o = sel;
      end else begin
        sw_ren_o = sel;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/regfield.sv ====
// One 32-bit register field with a fixed software access type and a hardware write port.
`timescale 1ns/1ps
`default_nettype none

module regfield #(
  parameter regblk_pkg::sw_access_e ACCESS  = regblk_pkg::ACS_RW,
  parameter regblk_pkg::data_t      RST_VAL = '0
) (
  input  logic              clk_i,
  input  logic              rst_i,
  // software strobe and data.
  // for an rc field the strobe is the read strobe of the register.
  input  logic              sw_wen_i,
  input  regblk_pkg::data_t sw_wdata_i,
  // direct write from the peripheral logic.
  input  logic              hw_wen_i,
  input  regblk_pkg::data_t hw_wdata_i,
  // registered software strobe, high the cycle after a software update.
  output logic              sw_upd_o,
  output regblk_pkg::data_t data_o
);

  regblk_pkg::data_t data_q;
  regblk_pkg::data_t data_d;

  // value the software bits act upon.
  // a hardware write in the same cycle replaces the stored value here.
  regblk_pkg::data_t base;

  assign base = hw_wen_i ? hw_wdata_i : data_q;

  // software takes priority over hardware on every bit it touches.
  always_comb begin
    data_d = data_q;
    case (ACCESS)
      regblk_pkg::ACS_RW, regblk_pkg::ACS_WO: begin
        if (sw_wen_i) begin
          data_d = sw_wdata_i;
        end else if (hw_wen_i) begin
          data_d = hw_wdata_i;
        end
      end
      regblk_pkg::ACS_W1C: begin
        // ones written by software clear the matching bits.
        data_d = sw_wen_i ? (base & ~sw_wdata_i) : base;
      end
      regblk_pkg::ACS_W1S: begin
        // ones written by software set the matching bits.
        data_d = sw_wen_i ? (base | sw_wdata_i) : base;
      end
      regblk_pkg::ACS_W0C: begin
        // zeros written by software clear the matching bits.
        data_d = sw_wen_i ? (base & sw_wdata_i) : base;
      end
      regblk_pkg::ACS_RC: begin
        // a read clears the whole register, even against a hardware write.
        data_d = sw_wen_i ? '0 : base;
      end
      default: begin
        // read-only fields follow the hardware alone.
        if (hw_wen_i) begin
          data_d = hw_wdata_i;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      data_q   <= RST_VAL;
      sw_upd_o <= 1'b0;
    end else begin
      data_q   <= data_d;
      sw_upd_o <= sw_wen_i;
    end
  end

  assign data_o = data_q;

endmodule

`default_nettype wire

// ==== hdl/reg_readback.sv ====
// Read-back stage; selects and masks the addressed field and registers it as APB read data.
`timescale 1ns/1ps
`default_nettype none

module reg_readback (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  // request strobe from the APB stage, high in the first access cycle.
  input  logic                                         req_i,
  // one-hot read strobe from the decoder.
  input  regblk_pkg::reg_sel_t                         sw_ren_i,
  // current value of every field.
  input  regblk_pkg::data_t [regblk_pkg::NUM_REGS-1:0] field_data_i,
  output regblk_pkg::data_t                            prdata_o
);

  // read data of the current request before it is registered.
  regblk_pkg::data_t rdata_d;
  regblk_pkg::data_t prdata_q;

  // writes and faulting accesses carry no read strobe and return zero.
  // write-only registers are masked so software never sees their contents.
  always_comb begin
    regblk_pkg::data_t mask;
    rdata_d = '0;
    mask    = '0;
    for (int i = 0; i < regblk_pkg::NUM_REGS; i++) begin
      mask = (regblk_pkg::REG_ACCESS[i] == regblk_pkg::ACS_WO) ? '0 : '1;
      if (sw_ren_i[i]) begin
        rdata_d = rdata_d | (field_data_i[i] & mask);
      end
    end
  end

  // the field value is sampled before the edge that applies a read clear.
  // an rc register therefore returns its value from before the clear.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prdata_q <= '0;
    end else if (req_i) begin
      prdata_q <= rdata_d;
    end
  end

  // the data is held until the next request.
  // it is only meaningful while pready is high.
  assign prdata_o = prdata_q;

endmodule

`default_nettype wire

// ==== hdl/regblk_top.sv ====
// Top level of the APB register block; connects the APB stage, decoder, fields and read-back.
`timescale 1ns/1ps
`default_nettype none

module regblk_top (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  // APB completer port.
  input  logic                                         psel_i,
  input  logic                                         penable_i,
  input  logic                                         pwrite_i,
  input  regblk_pkg::addr_t                            paddr_i,
  input  regblk_pkg::data_t                            pwdata_i,
  output regblk_pkg::data_t                            prdata_o,
  output logic                                         pready_o,
  output logic                                         pslverr_o,
  // hardware side of the peripheral.
  input  regblk_pkg::reg_sel_t                         hw_wen_i,
  input  regblk_pkg::data_t [regblk_pkg::NUM_REGS-1:0] hw_wdata_i,
  output regblk_pkg::data_t [regblk_pkg::NUM_REGS-1:0] reg_q_o,
  output regblk_pkg::reg_sel_t                         sw_upd_o
);

  // request from the APB stage, valid in the first access cycle.
  logic              req;
  logic              req_write;
  regblk_pkg::addr_t req_addr;
  regblk_pkg::data_t req_wdata;

  // decoder results.
  logic                 err;
  regblk_pkg::reg_sel_t sw_wen;
  regblk_pkg::reg_sel_t sw_ren;

  // value of every field, shared by the read-back and the peripheral.
  regblk_pkg::data_t [regblk_pkg::NUM_REGS-1:0] field_q;

  apb_access i_apb_access (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .err_i       (err),
    .req_o       (req),
    .req_write_o (req_write),
    .req_addr_o  (req_addr),
    .req_wdata_o (req_wdata),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o)
  );

  reg_decode i_reg_decode (
    .req_i       (req),
    .req_write_i (req_write),
    .req_addr_i  (req_addr),
    .sw_wen_o    (sw_wen),
    .sw_ren_o    (sw_ren),
    .err_o       (err)
  );

  // one field per register, typed from the register map.
  // the rc field is updated by its read strobe instead of a write strobe.
  for (genvar i = 0; i < regblk_pkg::NUM_REGS; i++) begin : gen_field
    regfield #(
      .ACCESS  (regblk_pkg::REG_ACCESS[i]),
      .RST_VAL (regblk_pkg::REG_RESET[i])
    ) i_regfield (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .sw_wen_i   ((regblk_pkg::REG_ACCESS[i] == regblk_pkg::ACS_RC) ? sw_ren[i] : sw_wen[i]),
      .sw_wdata_i (req_wdata),
      .hw_wen_i   (hw_wen_i[i]),
      .hw_wdata_i (hw_wdata_i[i]),
      .sw_upd_o   (sw_upd_o[i]),
      .data_o     (field_q[i])
    );
  end

  reg_readback i_reg_readback (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req),
    .sw_ren_i     (sw_ren),
    .field_data_i (field_q),
    .prdata_o     (prdata_o)
  );

  assign reg_q_o = field_q;

endmodule

`default_nettype wire

// ==== test/regblk_sva.sv ====
// APB protocol and response assertions, bound into regblk_top for simulation.
`timescale 1ns/1ps
`default_nettype none

module regblk_sva (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 psel_i,
  input logic                 penable_i,
  input logic                 pready_o,
  input logic                 pslverr_o,
  // write strobes from the decoder inside the block.
  input regblk_pkg::reg_sel_t sw_wen_i
);

  // the first access cycle is the only access cycle without pready.
  logic first_access;

  assign first_access = psel_i & penable_i & ~pready_o;

  // a response lasts one cycle.
  assert property (@(posedge clk_i) disable iff (rst_i) pready_o |=> !pready_o)
    else $error("pready_o stayed high for more than one cycle");

  // exactly one wait state, in both directions.
  assert property (@(posedge clk_i) disable iff (rst_i) first_access |=> pready_o)
    else $error("pready_o missing one cycle after the first access cycle");

  assert property (@(posedge clk_i) disable iff (rst_i) pready_o |-> $past(first_access))
    else $error("pready_o without a first access cycle just before it");

  assert property (@(posedge clk_i) disable iff (rst_i) pslverr_o |-> pready_o)
    else $error("pslverr_o high without pready_o");

  // at most one register is written per transfer.
  assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(sw_wen_i))
    else $error("more than one software write strobe active");

endmodule

bind regblk_top regblk_sva i_regblk_sva (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pready_o  (pready_o),
  .pslverr_o (pslverr_o),
  .sw_wen_i  (sw_wen)
);

`default_nettype wire

// ==== test/tb_regblk.sv ====
// Directed testbench for the APB register block; run it as the simulation top through tb.f.
`timescale 1ns/1ps
`default_nettype none

module tb_regblk;

  localparam int CLK_PERIOD      = 100;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 1000;
  // pready_o is due one cycle after the first access cycle, so a few cycles is plenty.
  localparam int MAX_WAIT        = 4;

  // register numbers in map order.
  localparam int CTRL_IDX   = 0;
  localparam int ID_IDX     = 1;
  localparam int KEY_IDX    = 2;
  localparam int STATUS_IDX = 3;
  localparam int EVENT_IDX  = 4;
  localparam int FLAGS_IDX  = 5;
  localparam int COUNT_IDX  = 6;

  logic                                         clk;
  logic                                         rst;
  logic                                         psel;
  logic                                         penable;
  logic                                         pwrite;
  regblk_pkg::addr_t                            paddr;
  regblk_pkg::data_t                            pwdata;
  regblk_pkg::data_t                            prdata;
  logic                                         pready;
  logic                                         pslverr;
  regblk_pkg::reg_sel_t                         hw_wen;
  regblk_pkg::data_t [regblk_pkg::NUM_REGS-1:0] hw_wdata;
  regblk_pkg::data_t [regblk_pkg::NUM_REGS-1:0] reg_q;
  regblk_pkg::reg_sel_t                         sw_upd;

  // expected value of every register.
  regblk_pkg::data_t model [regblk_pkg::NUM_REGS];

  // a hardware write that lands in the first access cycle of the next transfer.
  logic              coll_on;
  int                coll_idx;
  regblk_pkg::data_t coll_data;

  regblk_top i_dut (
    .clk_i      (clk),
    .rst_i      (rst),
    .psel_i     (psel),
    .penable_i  (penable),
    .pwrite_i   (pwrite),
    .paddr_i    (paddr),
    .pwdata_i   (pwdata),
    .prdata_o   (prdata),
    .pready_o   (pready),
    .pslverr_o  (pslverr),
    .hw_wen_i   (hw_wen),
    .hw_wdata_i (hw_wdata),
    .reg_q_o    (reg_q),
    .sw_upd_o   (sw_upd)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped after the first error");
  endtask

  task automatic check_value(input string name, input regblk_pkg::data_t exp,
                             input regblk_pkg::data_t act);
    assert (act === exp) else begin
      fail_run($sformatf("[ERROR] %0t ns: %s expected 0x%08h actual 0x%08h",
                         $time, name, exp, act));
    end
  endtask

  // reset values as the register map gives them.
  task automatic init_model();
    model[CTRL_IDX]   = 32'h0000_0000;
    model[ID_IDX]     = 32'h5245_4701;
    model[KEY_IDX]    = 32'h0000_0000;
    model[STATUS_IDX] = 32'h0000_0000;
    model[EVENT_IDX]  = 32'h0000_0000;
    model[FLAGS_IDX]  = 32'hFFFF_FFFF;
    model[COUNT_IDX]  = 32'h0000_0000;
  endtask

  // new register value after one clock edge.
  // the hardware data replaces the old value first, then the software bits act on it.
  function automatic regblk_pkg::data_t next_value(input int idx, input regblk_pkg::data_t cur,
                                                   input logic sw, input regblk_pkg::data_t sw_data,
                                                   input logic hw, input regblk_pkg::data_t hw_data);
    regblk_pkg::data_t base;
    regblk_pkg::data_t next;
    base = hw ? hw_data : cur;
    case (idx)
      CTRL_IDX, KEY_IDX: next = sw ? sw_data : base;
      STATUS_IDX:        next = sw ? (base & ~sw_data) : base;
      EVENT_IDX:         next = sw ? (base | sw_data) : base;
      FLAGS_IDX:         next = sw ? (base & sw_data) : base;
      COUNT_IDX:         next = sw ? '0 : base;
      default:           next = base;
    endcase
    return next;
  endfunction

  // register number of a mapped word address, or -1.
  function automatic int addr_index(input regblk_pkg::addr_t addr);
    if (addr[1:0] != 2'b00 || addr >= 8'h1C) begin
      return -1;
    end
    return int'(addr >> 2);
  endfunction

  function automatic regblk_pkg::addr_t addr_of(input int idx);
    return regblk_pkg::addr_t'(idx * 4);
  endfunction

  task automatic check_regs();
    for (int i = 0; i < regblk_pkg::NUM_REGS; i++) begin
      check_value($sformatf("reg_q_o[%0d]", i), model[i], reg_q[i]);
    end
  endtask

  // one hardware write, visible after the next edge.
  task automatic hw_write(input int idx, input regblk_pkg::data_t value);
    hw_wen        = regblk_pkg::reg_sel_t'(1) << idx;
    hw_wdata[idx] = value;
    @(negedge clk);
    hw_wen     = '0;
    model[idx] = next_value(idx, model[idx], 1'b0, '0, 1'b1, value);
    check_regs();
  endtask

  // one complete APB transfer, entered and left on a falling edge.
  task automatic apb_transfer(input logic write, input regblk_pkg::addr_t addr,
                              input regblk_pkg::data_t wdata);
    int                   idx;
    int                   waits;
    logic                 exp_err;
    logic                 sw_act;
    regblk_pkg::data_t    exp_rdata;
    regblk_pkg::reg_sel_t exp_upd;
    idx       = addr_index(addr);
    exp_err   = (idx < 0) || (write && idx == ID_IDX);
    // the rc register reacts to reads, every other register to writes.
    sw_act    = !exp_err && ((idx == COUNT_IDX) ? !write : write);
    exp_rdata = '0;
    if (!exp_err && !write && idx != KEY_IDX) begin
      exp_rdata = model[idx];
    end
    exp_upd = sw_act ? (regblk_pkg::reg_sel_t'(1) << idx) : '0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    hw_wen  = coll_on ? (regblk_pkg::reg_sel_t'(1) << coll_idx) : '0;
    if (coll_on) begin
      hw_wdata[coll_idx] = coll_data;
    end
    check_value("pready_o in first access cycle", '0, regblk_pkg::data_t'(pready));
    waits = 0;
    while (!pready && waits < MAX_WAIT) begin
      @(negedge clk);
      waits++;
      hw_wen = '0;
    end
    if (!pready) begin
      fail_run($sformatf("pready_o never came for the transfer to address 0x%02h", addr));
    end
    check_value("pready_o wait cycles", 32'd1, regblk_pkg::data_t'(waits));
    check_value("pslverr_o", regblk_pkg::data_t'(exp_err), regblk_pkg::data_t'(pslverr));
    check_value("prdata_o", exp_rdata, prdata);
    check_value("sw_upd_o", regblk_pkg::data_t'(exp_upd), regblk_pkg::data_t'(sw_upd));
    for (int i = 0; i < regblk_pkg::NUM_REGS; i++) begin
      model[i] = next_value(i, model[i], sw_act && (i == idx), wdata,
                            coll_on && (i == coll_idx), coll_data);
    end
    coll_on = 1'b0;
    check_regs();
    // the transfer completes on the next rising edge, then the bus goes idle.
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input regblk_pkg::addr_t addr, input regblk_pkg::data_t data);
    apb_transfer(1'b1, addr, data);
  endtask

  task automatic apb_read(input regblk_pkg::addr_t addr);
    apb_transfer(1'b0, addr, '0);
  endtask

  task automatic read_reset_values();
    check_value("pready_o after reset", '0, regblk_pkg::data_t'(pready));
    check_value("pslverr_o after reset", '0, regblk_pkg::data_t'(pslverr));
    check_value("sw_upd_o after reset", '0, regblk_pkg::data_t'(sw_upd));
    check_value("prdata_o after reset", '0, prdata);
    check_regs();
    for (int i = 0; i < regblk_pkg::NUM_REGS; i++) begin
      apb_read(addr_of(i));
    end
  endtask

  task automatic write_ctrl_and_key();
    repeat (4) begin
      apb_write(addr_of(CTRL_IDX), $urandom);
      apb_read(addr_of(CTRL_IDX));
    end
    // KEY keeps what software wrote but always reads as zero.
    repeat (2) begin
      apb_write(addr_of(KEY_IDX), $urandom);
      apb_read(addr_of(KEY_IDX));
    end
  endtask

  task automatic reject_bad_accesses();
    apb_write(addr_of(ID_IDX), $urandom);
    apb_write(8'h1C, $urandom);
    apb_read(8'h1C);
    apb_read(8'h40);
    apb_write(8'hFC, $urandom);
    apb_read(8'h02);
    apb_write(8'h05, $urandom);
    hw_write(ID_IDX, $urandom);
    apb_read(addr_of(ID_IDX));
  endtask

  task automatic exercise_bit_access();
    for (int idx = STATUS_IDX; idx <= FLAGS_IDX; idx++) begin
      hw_write(idx, $urandom);
      apb_write(addr_of(idx), $urandom);
      apb_read(addr_of(idx));
      // hardware and software hit the same register in the same cycle.
      coll_on   = 1'b1;
      coll_idx  = idx;
      coll_data = $urandom;
      apb_write(addr_of(idx), $urandom);
      apb_read(addr_of(idx));
    end
  endtask

  task automatic clear_count_on_read();
    hw_write(COUNT_IDX, $urandom | 32'h1);
    apb_read(addr_of(COUNT_IDX));
    apb_read(addr_of(COUNT_IDX));
    hw_write(COUNT_IDX, $urandom | 32'h1);
    // the read clear must win over a hardware load in the same cycle.
    coll_on   = 1'b1;
    coll_idx  = COUNT_IDX;
    coll_data = $urandom | 32'h1;
    apb_read(addr_of(COUNT_IDX));
    apb_read(addr_of(COUNT_IDX));
  endtask

  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    fail_run("watchdog timeout, the tests did not finish in the allowed number of cycles");
  end

  initial begin
    void'($urandom(32'hc62f));
    rst       = 1'b1;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    hw_wen    = '0;
    hw_wdata  = '0;
    coll_on   = 1'b0;
    coll_idx  = 0;
    coll_data = '0;
    init_model();
    repeat (10) @(negedge clk);
    rst = 1'b0;
    read_reset_values();
    write_ctrl_and_key();
    reject_bad_accesses();
    exercise_bit_access();
    clear_count_on_read();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/regblk_pkg.sv
hdl/apb_access.sv
hdl/reg_decode.sv
hdl/regfield.sv
hdl/reg_readback.sv
hdl/regblk_top.sv
test/regblk_sva.sv
test/tb_regblk.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the register block testbench with Verilator and runs it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing \
  --top-module tb_regblk \
  -Mdir obj_dir \
  -f tb.f

./obj_dir/Vtb_regblk
